/* tb.f */
design/kernel_pkg.sv
design/image_pkg.sv
design/pixel_window.sv
design/channel_blur.sv
design/blur_output_stage.sv
design/blurring_filter.sv
+incdir+verif
verif/tb_blurring_filter.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the blur filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_blurring_filter \
    -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

/* verif/blur_model.svh */
// Blur weights per window tap in [line][pixel] order, summing to 64
localparam int blur_weight [5][7] = '{
    '{1, 1, 2, 2, 2, 1, 1},
    '{1, 2, 2, 4, 2, 2, 1},
    '{0, 2, 4, 4, 4, 2, 0},
    '{1, 2, 2, 4, 2, 2, 1},
    '{1, 1, 2, 2, 2, 1, 1}
};

// img_w, warmup_len and frame_len come from the including module
// Pixels of the current frame in order from the start of packet
image_pkg::rgb444_t frame_mem [frame_len];

int unsigned lcg_state = 10;

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

// Output expected one cycle after pixel n of the frame is accepted
function automatic image_pkg::rgb444_t expected_pixel(input int n);
    int                 sum_r;
    int                 sum_g;
    int                 sum_b;
    int                 base;
    image_pkg::rgb444_t px;
    image_pkg::rgb444_t ref_px;
    image_pkg::rgb444_t result;
    if (n < warmup_len) begin
        return '0;
    end
    sum_r = 0;
    sum_g = 0;
    sum_b = 0;
    // Oldest pixel of the window sits warmup_len pixels back
    base = n - warmup_len;
    for (int r = 0; r < 5; r++) begin
        for (int c = 0; c < 7; c++) begin
            px = frame_mem[base + r * img_w + c];
            sum_r = sum_r + blur_weight[r][c] * int'(px.red);
            sum_g = sum_g + blur_weight[r][c] * int'(px.green);
            sum_b = sum_b + blur_weight[r][c] * int'(px.blue);
        end
    end
    sum_r = sum_r / 64;
    sum_g = sum_g / 64;
    sum_b = sum_b / 64;
    ref_px = frame_mem[base];
    // Bright pixels are averaged with the reference pixel
    if (sum_r > 10 && sum_g > 10 && sum_b > 10) begin
        sum_r = (sum_r + int'(ref_px.red)) / 2;
        sum_g = (sum_g + int'(ref_px.green)) / 2;
        sum_b = (sum_b + int'(ref_px.blue)) / 2;
    end
    result.red   = image_pkg::chan_t'(sum_r);
    result.green = image_pkg::chan_t'(sum_g);
    result.blue  = image_pkg::chan_t'(sum_b);
    return result;
endfunction

/* verif/tb_blurring_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_blurring_filter;

    localparam int img_w      = 16;
    localparam int warmup_len = 4 * img_w + 6;
    localparam int frame_len  = 6 * img_w;
    localparam int restart_at = 80;
    // Pixels sent over all tests
    localparam int pixels_sent = warmup_len + 6 * frame_len + restart_at;
    // Gaps may double the cycle count and the limit keeps four times that
    localparam int max_cycles  = 4 * 2 * pixels_sent + 100;

    logic        clk;
    logic        rst_n;
    logic        ready;
    logic        valid;
    logic        startofpacket_in;
    logic [11:0] data_in;
    logic [11:0] data_out;

    int          error_count = 0;
    int          check_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    logic [11:0] last_out;

    `include "blur_model.svh"

    blurring_filter #(
        .image_width (img_w)
    ) u_blurring_filter (
        .clk              (clk),
        .rst_n            (rst_n),
        .ready            (ready),
        .valid            (valid),
        .startofpacket_in (startofpacket_in),
        .data_in          (data_in),
        .data_out         (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("sim failed");
        $finish;
    end

    task automatic check_value(input string name, input int n, input logic [11:0] expected);
        check_count++;
        if (data_out !== expected) begin
            $display("CHECK FAILED at %0t ns: %s for pixel %0d expected %h got %h",
                     $time, name, n, expected, data_out);
            error_count++;
        end
    endtask

    // Streams n_pixels of frame_mem, dropping ready and valid at gap_pct percent
    task automatic run_frame(input int n_pixels, input int gap_pct);
        int          sent;
        int          idx1;
        int          idx2;
        bit          acc1;
        bit          acc2;
        logic [11:0] exp1;
        logic [11:0] exp2;
        bit          rdy;
        bit          vld;
        sent = 0;
        acc1 = 1'b0;
        acc2 = 1'b0;
        idx1 = 0;
        idx2 = 0;
        exp1 = '0;
        exp2 = '0;
        while (sent < n_pixels || acc1 || acc2) begin
            @(negedge clk);
            // data_out reflects the accept two rising edges back
            if (acc2) begin
                check_value("data_out", idx2, exp2);
                last_out = exp2;
            end else begin
                check_value("data_out (held)", idx2, last_out);
            end
            acc2 = acc1;
            exp2 = exp1;
            idx2 = idx1;
            rdy = (sent < n_pixels);
            vld = (sent < n_pixels);
            if (gap_pct > 0 && (lcg_next() % 100) < gap_pct) begin
                rdy = 1'b0;
            end
            if (gap_pct > 0 && (lcg_next() % 100) < gap_pct) begin
                vld = 1'b0;
            end
            ready = rdy;
            valid = vld;
            acc1 = rdy && vld;
            startofpacket_in = acc1 && (sent == 0);
            data_in = (sent < n_pixels) ? frame_mem[sent] : 12'h000;
            if (acc1) begin
                exp1 = expected_pixel(sent);
                idx1 = sent;
                sent++;
            end
        end
    endtask

    task automatic fill_random();
        int unsigned value;
        for (int i = 0; i < frame_len; i++) begin
            value = lcg_next();
            frame_mem[i] = value[11:0];
        end
    endtask

    task automatic fill_constant(input logic [11:0] px);
        for (int i = 0; i < frame_len; i++) begin
            frame_mem[i] = px;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("FAIL %s with %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    task automatic warm_up_zeros();
        int errors_before;
        errors_before = error_count;
        fill_constant(12'h9c5);
        run_frame(warmup_len, 0);
        report_test("warm-up", errors_before);
    endtask

    task automatic uniform_grey();
        int errors_before;
        errors_before = error_count;
        fill_constant(12'h444);
        run_frame(frame_len, 0);
        report_test("uniform frame", errors_before);
    endtask

    task automatic noise_averaging();
        int errors_before;
        errors_before = error_count;
        fill_constant(12'heee);
        run_frame(frame_len, 0);
        // Dark pixels among bright ones land on the reference tap at some positions
        for (int i = 0; i < frame_len; i++) begin
            frame_mem[i] = (i % 13 == 5) ? 12'h000 : 12'heee;
        end
        run_frame(frame_len, 0);
        report_test("noise averaging", errors_before);
    endtask

    task automatic random_frame();
        int errors_before;
        errors_before = error_count;
        fill_random();
        run_frame(frame_len, 0);
        report_test("random frame", errors_before);
    endtask

    task automatic back_pressure_gaps();
        int errors_before;
        errors_before = error_count;
        run_frame(frame_len, 25);
        report_test("back-pressure", errors_before);
    endtask

    task automatic frame_restart();
        int errors_before;
        errors_before = error_count;
        fill_random();
        run_frame(restart_at, 0);
        // New start of packet before the first frame is complete
        fill_random();
        run_frame(frame_len, 0);
        report_test("frame restart", errors_before);
    endtask

    initial begin
        rst_n = 1'b0;
        ready = 1'b0;
        valid = 1'b0;
        startofpacket_in = 1'b0;
        data_in = '0;
        last_out = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("data_out after reset", 0, 12'h000);
        warm_up_zeros();
        uniform_grey();
        noise_averaging();
        random_frame();
        back_pressure_gaps();
        frame_restart();
        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/blurring_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module blurring_filter #(
    parameter int image_width = 320
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ready,
    input  logic                          valid,
    input  logic                          startofpacket_in,
    input  logic [image_pkg::pixel_w-1:0] data_in,
    output logic [image_pkg::pixel_w-1:0] data_out
);

    image_pkg::window_t window;
    image_pkg::chan_t   red_blur;
    image_pkg::chan_t   green_blur;
    image_pkg::chan_t   blue_blur;
    logic               filled;
    logic               shifted;

    pixel_window #(
        .image_width (image_width)
    ) u_window (
        .clk              (clk),
        .rst_n            (rst_n),
        .ready            (ready),
        .valid            (valid),
        .startofpacket_in (startofpacket_in),
        .data_in          (data_in),
        .window           (window),
        .filled           (filled),
        .shifted          (shifted)
    );

    // One blur per colour channel
    channel_blur #(.channel(0)) u_red_blur (
        .window  (window),
        .blurred (red_blur)
    );

    channel_blur #(.channel(1)) u_green_blur (
        .window  (window),
        .blurred (green_blur)
    );

    channel_blur #(.channel(2)) u_blue_blur (
        .window  (window),
        .blurred (blue_blur)
    );

    blur_output_stage u_output (
        .clk        (clk),
        .rst_n      (rst_n),
        .shifted    (shifted),
        .filled     (filled),
        .window     (window),
        .red_blur   (red_blur),
        .green_blur (green_blur),
        .blue_blur  (blue_blur),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

/* design/blur_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module blur_output_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               shifted,
    input  logic               filled,
    input  image_pkg::window_t window,
    input  image_pkg::chan_t   red_blur,
    input  image_pkg::chan_t   green_blur,
    input  image_pkg::chan_t   blue_blur,
    output image_pkg::rgb444_t data_out
);

    image_pkg::rgb444_t ref_px;
    image_pkg::rgb444_t next_px;
    logic               bright;

    // Mean of two channel values, rounded down
    function automatic image_pkg::chan_t average(
        input image_pkg::chan_t a,
        input image_pkg::chan_t b
    );
        logic [image_pkg::chan_w:0] total;
        total = {1'b0, a} + {1'b0, b};
        return total[image_pkg::chan_w:1];
    endfunction

    // Oldest pixel in the window
    assign ref_px = window[0][0];

    assign bright = (red_blur > kernel_pkg::noise_threshold)
                 && (green_blur > kernel_pkg::noise_threshold)
                 && (blue_blur > kernel_pkg::noise_threshold);

    always_comb begin
        if (!filled) begin
            // Window still holds cleared entries
            next_px = '0;
        end else if (bright) begin
            // Pull bright areas back toward the original pixel
            next_px.red   = average(red_blur, ref_px.red);
            next_px.green = average(green_blur, ref_px.green);
            next_px.blue  = average(blue_blur, ref_px.blue);
        end else begin
            next_px.red   = red_blur;
            next_px.green = green_blur;
            next_px.blue  = blue_blur;
        end
    end

    // One new pixel per accept, held otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (shifted) begin
            data_out <= next_px;
        end
    end

endmodule

`default_nettype wire

/* design/channel_blur.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_blur #(
    // 0 red, 1 green, 2 blue
    parameter int channel = 0
) (
    input  image_pkg::window_t window,
    output image_pkg::chan_t   blurred
);

    kernel_pkg::sum_t sum;

    function automatic image_pkg::chan_t pick(input image_pkg::rgb444_t px);
        case (channel)
            0:       return px.red;
            1:       return px.green;
            default: return px.blue;
        endcase
    endfunction

    // Weighted sum over the whole window
    always_comb begin
        sum = '0;
        for (int r = 0; r < kernel_pkg::kernel_rows; r++) begin
            for (int c = 0; c < kernel_pkg::kernel_cols; c++) begin
                if (kernel_pkg::blur_shift[r][c] != kernel_pkg::shift_zero) begin
                    sum = sum + (kernel_pkg::sum_t'(pick(window[r][c]))
                                 << kernel_pkg::blur_shift[r][c]);
                end
            end
        end
    end

    // Divide by 64, the sum of the weights
    assign blurred = image_pkg::chan_t'(sum >> kernel_pkg::norm_shift);

endmodule

`default_nettype wire

/* design/pixel_window.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_window #(
    parameter int image_width = 320
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ready,
    input  logic                valid,
    input  logic                startofpacket_in,
    input  image_pkg::rgb444_t  data_in,
    output image_pkg::window_t  window,
    output logic                filled,
    output logic                shifted
);

    // Four full lines plus one window width
    localparam int depth = (kernel_pkg::kernel_rows - 1) * image_width
                           + kernel_pkg::kernel_cols;
    localparam int count_w = $clog2(depth + 1);
    localparam logic [count_w-1:0] fill_point = count_w'(depth);

    image_pkg::rgb444_t buffer [depth];
    logic [count_w-1:0] fill_count;
    logic               accept;

    assign accept = ready && valid;

    // Index 0 is the oldest entry, new pixels enter at the top
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                buffer[i] <= '0;
            end
        end else if (accept) begin
            // A start of packet flushes the old frame before this pixel enters
            for (int i = 0; i < depth - 1; i++) begin
                buffer[i] <= startofpacket_in ? '0 : buffer[i+1];
            end
            buffer[depth-1] <= data_in;
        end else if (startofpacket_in) begin
            for (int i = 0; i < depth; i++) begin
                buffer[i] <= '0;
            end
        end
    end

    // Accepted pixels since the last clear, saturating once the window is full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_count <= '0;
        end else if (accept) begin
            if (startofpacket_in) begin
                fill_count <= count_w'(1);
            end else if (!filled) begin
                fill_count <= fill_count + 1'b1;
            end
        end else if (startofpacket_in) begin
            fill_count <= '0;
        end
    end

    assign filled = (fill_count == fill_point);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shifted <= 1'b0;
        end else begin
            shifted <= accept;
        end
    end

    // Taps at line stride image_width
    for (genvar r = 0; r < kernel_pkg::kernel_rows; r++) begin : g_row
        for (genvar c = 0; c < kernel_pkg::kernel_cols; c++) begin : g_col
            assign window[r][c] = buffer[r*image_width + c];
        end
    end

endmodule

`default_nettype wire

/* design/image_pkg.sv */
`default_nettype none

package image_pkg;

    // One colour channel of an RGB444 pixel
    localparam int chan_w = 4;

    // Full pixel, three channels side by side
    localparam int pixel_w = 3 * chan_w;

    typedef logic [chan_w-1:0] chan_t;

    // Red sits in the top nibble, blue in the bottom one
    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb444_t;

    // Filter window, indexed [line][pixel]
    // Entry [0][0] is the oldest pixel held, larger indices are newer
    typedef rgb444_t [kernel_pkg::kernel_rows-1:0][kernel_pkg::kernel_cols-1:0] window_t;

endpackage

`default_nettype wire

/* design/kernel_pkg.sv */
`default_nettype none

package kernel_pkg;

    // Window size seen by the blur
    localparam int kernel_rows = 5;
    localparam int kernel_cols = 7;

    // Largest sum is 15 * 64 = 960
    localparam int sum_w = 10;
    typedef logic [sum_w-1:0] sum_t;

    // Weights add up to 64
    localparam int norm_shift = 6;

    // All three blurred channels above this count as bright
    localparam int noise_threshold = 10;

    // Weight of each tap as a left shift, or shift_zero for no contribution
    typedef logic [2:0] shift_t;
    localparam shift_t shift_zero = 3'd7;

    // Weights 1 1 2 2 2 1 1 / 1 2 2 4 2 2 1 / 0 2 4 4 4 2 0 / ... (symmetric)
    localparam shift_t blur_shift [kernel_rows][kernel_cols] = '{
        '{3'd0, 3'd0, 3'd1, 3'd1, 3'd1, 3'd0, 3'd0},
        '{3'd0, 3'd1, 3'd1, 3'd2, 3'd1, 3'd1, 3'd0},
        '{shift_zero, 3'd1, 3'd2, 3'd2, 3'd2, 3'd1, shift_zero},
        '{3'd0, 3'd1, 3'd1, 3'd2, 3'd1, 3'd1, 3'd0},
        '{3'd0, 3'd0, 3'd1, 3'd1, 3'd1, 3'd0, 3'd0}
    };

endpackage

`default_nettype wire
